// ==== rtl/ucpd_pkg.sv ====
package ucpd_pkg;

  // ----------------------------------------------------------
  // Data types
  // ----------------------------------------------------------
  typedef logic [31:0] data_t;       // APB data word
  typedef logic [5:0]  addr_t;       // Register word offset
  typedef logic [7:0]  byte_t;       // TX or RX data byte
  typedef logic [6:0]  tx_status_t;  // Flags from the transmitter
  typedef logic [5:0]  rx_status_t;  // Flags from the receiver

  // ----------------------------------------------------------
  // Register word offsets
  // ----------------------------------------------------------
  localparam addr_t ADDR_CFG1 = 6'd0;   // Byte offset 0x00
  localparam addr_t ADDR_CR   = 6'd3;   // 0x0c
  localparam addr_t ADDR_IMR  = 6'd4;   // 0x10
  localparam addr_t ADDR_SR   = 6'd5;   // 0x14
  localparam addr_t ADDR_ICR  = 6'd6;   // 0x18, write only
  localparam addr_t ADDR_TXDR = 6'd9;   // 0x24
  localparam addr_t ADDR_RXDR = 6'd12;  // 0x30, read only

  // ----------------------------------------------------------
  // Status register layout
  // ----------------------------------------------------------
  localparam int unsigned SR_TXIS_BIT = 0;   // TX data register empty
  localparam int unsigned SR_TX_FIRST = 1;   // tx_status[6:1] -> SR[6:1]
  localparam int unsigned SR_RXNE_BIT = 8;   // RX data register not empty
  localparam int unsigned SR_RX_FIRST = 9;   // rx_status[5:1] -> SR[13:9]
  localparam int unsigned SR_FRS_BIT  = 20;  // Fast role swap

  // Bits 0-6, 8-13 and 20
  localparam data_t SR_USED_MASK = 32'h0010_3f7f;

endpackage

// ==== rtl/ucpd_status_if.sv ====
`timescale 1ns/1ps

// Events, clear strobes and status word between the register blocks
interface ucpd_status_if import ucpd_pkg::*; ();

  tx_status_t tx_evt;   // Rising edges of tx_status, one cycle each
  rx_status_t rx_evt;   // Rising edges of rx_status
  logic       frs_evt;  // Rising edge of fast role swap
  data_t      icr_clr;  // ICR write data, only in the write cycle
  logic       rxdr_rd;  // RXDR read strobe
  logic       txdr_we;  // TXDR write strobe
  data_t      sr;       // Registered status word

  // Edge detector side
  modport capture (
    output tx_evt, rx_evt, frs_evt
  );

  // Register decode side
  modport bank (
    output icr_clr, rxdr_rd, txdr_we,
    input  sr
  );

  // Sticky status side
  modport status (
    input  tx_evt, rx_evt, frs_evt, icr_clr, rxdr_rd, txdr_we,
    output sr
  );

endinterface

// ==== rtl/ucpd_reg_bank.sv ====
`timescale 1ns/1ps

module ucpd_reg_bank import ucpd_pkg::*; (
  input  logic       pclk,
  input  logic       presetn,
  input  logic       wr_en,          // Write strobe, one cycle
  input  logic       rd_en,          // Read strobe
  input  addr_t      reg_addr,       // Word offset
  input  data_t      ipwdata,
  input  byte_t      rx_byte,        // Byte from the receiver
  input  logic       txhrst_clr,     // Hard reset sent, drop CR.TXHRST
  input  logic       txsend_clr,     // Message sent, drop CR.TXSEND
  ucpd_status_if.bank st,
  output data_t      iprdata,
  output logic       ucpden,
  output logic [5:0] hbitclkdiv,
  output logic [4:0] ifrgap,
  output logic [4:0] transwin,
  output logic [2:0] psc_usbpdclk,
  output logic [8:0] rx_ordset_en,
  output logic [1:0] tx_mode,
  output logic       transmit_en,
  output logic       tx_hrst,
  output logic       phy_rx_en,
  output byte_t      ic_txdr,
  output logic       txdr_we,
  output logic       rxdr_rd,
  output data_t      imr
);

  data_t cfg1_q;   // Bit 31 is the block enable
  data_t cr_q;
  data_t imr_q;
  byte_t txdr_q;

  logic cfg1_sel, cr_sel, imr_sel, icr_sel, txdr_sel, rxdr_sel;
  logic cfg1_we, cr_we, imr_we, icr_we, txdr_wr;

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------
  assign cfg1_sel = (reg_addr == ADDR_CFG1);
  assign cr_sel   = (reg_addr == ADDR_CR);
  assign imr_sel  = (reg_addr == ADDR_IMR);
  assign icr_sel  = (reg_addr == ADDR_ICR);
  assign txdr_sel = (reg_addr == ADDR_TXDR);
  assign rxdr_sel = (reg_addr == ADDR_RXDR);

  // CFG1 is always writable, the rest only while enabled
  assign cfg1_we = cfg1_sel & wr_en;
  assign cr_we   = cr_sel   & wr_en & ucpden;
  assign imr_we  = imr_sel  & wr_en & ucpden;
  assign icr_we  = icr_sel  & wr_en & ucpden;
  assign txdr_wr = txdr_sel & wr_en & ucpden;

  // ----------------------------------------------------------
  // CFG1
  // ----------------------------------------------------------
  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      cfg1_q <= '0;
    end else if (cfg1_we) begin
      if (ipwdata[31]) begin
        cfg1_q[31] <= 1'b1;              // Enable, fields untouched
      end else begin
        cfg1_q <= {1'b0, ipwdata[30:0]}; // Disable and reload fields
      end
    end
  end

  assign ucpden       = cfg1_q[31];
  assign rx_ordset_en = cfg1_q[28:20];
  assign psc_usbpdclk = cfg1_q[19:17];
  assign transwin     = cfg1_q[15:11];
  assign ifrgap       = cfg1_q[10:6];
  assign hbitclkdiv   = cfg1_q[5:0];

  // ----------------------------------------------------------
  // CR with hardware clears
  // ----------------------------------------------------------
  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      cr_q <= '0;
    end else if (cr_we) begin
      cr_q <= ipwdata;         // Software write has priority
    end else begin
      if (txhrst_clr) begin
        cr_q[3] <= 1'b0;
      end
      if (txsend_clr) begin
        cr_q[2] <= 1'b0;
      end
    end
  end

  assign tx_mode     = cr_q[1:0];
  assign transmit_en = cr_q[2];
  assign tx_hrst     = cr_q[3];
  assign phy_rx_en   = cr_q[5];

  // IMR and TXDR
  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      imr_q  <= '0;
      txdr_q <= '0;
    end else begin
      if (imr_we) begin
        imr_q <= ipwdata;
      end
      if (txdr_wr) begin
        txdr_q <= ipwdata[7:0];
      end
    end
  end

  assign imr     = imr_q;
  assign ic_txdr = txdr_q;

  // ----------------------------------------------------------
  // Strobes to the status register
  // ----------------------------------------------------------
  assign st.icr_clr = icr_we ? ipwdata : '0;   // Clear pulse only in the write cycle
  assign txdr_we    = txdr_wr;                 // Same cycle as the TXDR write
  assign rxdr_rd    = rxdr_sel & rd_en;
  assign st.txdr_we = txdr_wr;
  assign st.rxdr_rd = rxdr_rd;

  // ----------------------------------------------------------
  // Read mux
  // ----------------------------------------------------------
  always_comb begin
    case (reg_addr)
      ADDR_CFG1: iprdata = cfg1_q;
      ADDR_CR:   iprdata = cr_q;
      ADDR_IMR:  iprdata = imr_q;
      ADDR_SR:   iprdata = st.sr;
      ADDR_TXDR: iprdata = {24'd0, txdr_q};
      ADDR_RXDR: iprdata = {24'd0, rx_byte};   // Receive byte passes straight through
      default:   iprdata = '0;                 // ICR and unmapped offsets
    endcase
  end

endmodule

// ==== rtl/ucpd_event_capture.sv ====
`timescale 1ns/1ps

module ucpd_event_capture import ucpd_pkg::*; #(
  parameter int unsigned SYNC_STAGES = 2   // Synchronizer depth
) (
  input  logic       pclk,
  input  logic       presetn,
  input  tx_status_t tx_status,   // From the transmitter clock domain
  input  rx_status_t rx_status,   // From the receiver clock domain
  input  logic       frs_evt,     // Fast role swap detector
  ucpd_status_if.capture st
);

  localparam int unsigned TX_W   = $bits(tx_status_t);
  localparam int unsigned RX_W   = $bits(rx_status_t);
  localparam int unsigned NFLAGS = TX_W + RX_W + 1;   // 14 flags

  logic [NFLAGS-1:0]                  flags_in;
  logic [SYNC_STAGES-1:0][NFLAGS-1:0] sync_q;       // Stage 0 samples the raw flags
  logic [NFLAGS-1:0]                  flags_sync;
  logic [NFLAGS-1:0]                  flags_d;      // One cycle behind flags_sync
  logic [NFLAGS-1:0]                  flags_rise;

  // FRS on top, then RX, TX in the low bits
  assign flags_in = {frs_evt, rx_status, tx_status};

  // ----------------------------------------------------------
  // Synchronizer chain
  // ----------------------------------------------------------
  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= flags_in;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign flags_sync = sync_q[SYNC_STAGES-1];

  // ----------------------------------------------------------
  // Rising-edge detect
  // ----------------------------------------------------------
  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      flags_d <= '0;
    end else begin
      flags_d <= flags_sync;
    end
  end

  assign flags_rise = flags_sync & ~flags_d;   // High for one cycle per edge

  assign st.tx_evt  = flags_rise[TX_W-1:0];
  assign st.rx_evt  = flags_rise[TX_W +: RX_W];
  assign st.frs_evt = flags_rise[NFLAGS-1];

endmodule

// ==== rtl/ucpd_status_reg.sv ====
`timescale 1ns/1ps

module ucpd_status_reg import ucpd_pkg::*; (
  input  logic  pclk,
  input  logic  presetn,
  input  data_t imr,          // Interrupt mask from the bank
  ucpd_status_if.status st,
  output logic  ucpd_intr     // Level interrupt
);

  // ICR reaches every used bit except TXIS and RXNE
  localparam data_t ICR_CLR_MASK = SR_USED_MASK &
                                   ~((data_t'(1) << SR_TXIS_BIT) |
                                     (data_t'(1) << SR_RXNE_BIT));

  data_t sr_q;
  data_t sr_set;   // Set requests this cycle
  data_t sr_clr;   // Clear requests this cycle

  // ----------------------------------------------------------
  // Map events onto status bits
  // ----------------------------------------------------------
  always_comb begin
    sr_set = '0;
    sr_set[SR_TXIS_BIT]                          = st.tx_evt[0];
    sr_set[SR_TX_FIRST +: $bits(tx_status_t)-1]  = st.tx_evt[$bits(tx_status_t)-1:1];
    sr_set[SR_RXNE_BIT]                          = st.rx_evt[0];
    sr_set[SR_RX_FIRST +: $bits(rx_status_t)-1]  = st.rx_evt[$bits(rx_status_t)-1:1];
    sr_set[SR_FRS_BIT]                           = st.frs_evt;
  end

  // Clear sources
  always_comb begin
    sr_clr = st.icr_clr & ICR_CLR_MASK;
    sr_clr[SR_TXIS_BIT] = st.txdr_we;   // New TX byte loaded
    sr_clr[SR_RXNE_BIT] = st.rxdr_rd;   // RX byte taken
  end

  // ----------------------------------------------------------
  // Sticky bits, clear beats set
  // ----------------------------------------------------------
  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      sr_q <= '0;
    end else begin
      sr_q <= (sr_q | sr_set) & ~sr_clr & SR_USED_MASK;
    end
  end

  assign st.sr     = sr_q;
  assign ucpd_intr = |(sr_q & imr);   // Any unmasked status

endmodule

// ==== rtl/ucpd_regs_top.sv ====
`timescale 1ns/1ps

module ucpd_regs_top import ucpd_pkg::*; #(
  parameter int unsigned SYNC_STAGES = 2   // Status input synchronizer depth
) (
  input  logic       pclk,
  input  logic       presetn,
  // Register access
  input  logic       wr_en,
  input  logic       rd_en,
  input  addr_t      reg_addr,
  input  data_t      ipwdata,
  output data_t      iprdata,
  // Status from the PHY side
  input  tx_status_t tx_status,
  input  rx_status_t rx_status,
  input  logic       frs_evt,
  input  byte_t      rx_byte,
  input  logic       txhrst_clr,
  input  logic       txsend_clr,
  // CFG1 fields
  output logic       ucpden,
  output logic [5:0] hbitclkdiv,
  output logic [4:0] ifrgap,
  output logic [4:0] transwin,
  output logic [2:0] psc_usbpdclk,
  output logic [8:0] rx_ordset_en,
  // CR fields
  output logic [1:0] tx_mode,
  output logic       transmit_en,
  output logic       tx_hrst,
  output logic       phy_rx_en,
  // Data path strobes
  output byte_t      ic_txdr,
  output logic       txdr_we,
  output logic       rxdr_rd,
  output logic       ucpd_intr
);

  data_t imr;   // Mask from bank to status register

  ucpd_status_if st_if ();

  // ----------------------------------------------------------
  // Register decode and writable registers
  // ----------------------------------------------------------
  ucpd_reg_bank u_reg_bank (
    .pclk         (pclk),
    .presetn      (presetn),
    .wr_en        (wr_en),
    .rd_en        (rd_en),
    .reg_addr     (reg_addr),
    .ipwdata      (ipwdata),
    .rx_byte      (rx_byte),
    .txhrst_clr   (txhrst_clr),
    .txsend_clr   (txsend_clr),
    .st           (st_if.bank),
    .iprdata      (iprdata),
    .ucpden       (ucpden),
    .hbitclkdiv   (hbitclkdiv),
    .ifrgap       (ifrgap),
    .transwin     (transwin),
    .psc_usbpdclk (psc_usbpdclk),
    .rx_ordset_en (rx_ordset_en),
    .tx_mode      (tx_mode),
    .transmit_en  (transmit_en),
    .tx_hrst      (tx_hrst),
    .phy_rx_en    (phy_rx_en),
    .ic_txdr      (ic_txdr),
    .txdr_we      (txdr_we),
    .rxdr_rd      (rxdr_rd),
    .imr          (imr)
  );

  // Sync and edge detect of status inputs
  ucpd_event_capture #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_event_capture (
    .pclk      (pclk),
    .presetn   (presetn),
    .tx_status (tx_status),
    .rx_status (rx_status),
    .frs_evt   (frs_evt),
    .st        (st_if.capture)
  );

  ucpd_status_reg u_status_reg (
    .pclk      (pclk),
    .presetn   (presetn),
    .imr       (imr),
    .st        (st_if.status),
    .ucpd_intr (ucpd_intr)
  );

endmodule

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps

// Free-running testbench clock
module tb_clk_gen #(
  parameter real PERIOD = 4.0   // ns
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always begin
    #(PERIOD / 2.0);
    clk = ~clk;   // Half period per toggle
  end

endmodule

// ==== test/tb_checker.sv ====
`timescale 1ns/1ps

// Watches the DUT ports and compares them against the model values from tb_top
module tb_checker import ucpd_pkg::*; (
  input  logic        pclk,
  input  int          test_id,
  input  logic        test_done,     // Last cycle of a test
  input  logic        all_done,      // Last cycle of the run
  input  logic        chk_on,
  input  logic        chk_rd,        // Compare read data this cycle
  input  logic        chk_intr,      // Off while SR is being polled
  input  data_t       exp_rdata,
  input  logic        exp_intr,
  input  logic        exp_txdr_we,
  input  logic        exp_rxdr_rd,
  input  logic [41:0] exp_ctrl,
  input  logic [41:0] act_ctrl,      // Packed CFG1, CR and TXDR ports
  input  data_t       iprdata,
  input  logic        ucpd_intr,
  input  logic        txdr_we,
  input  logic        rxdr_rd,
  output int          err_total
);

  int n_checks  = 0;
  int test_errs = 0;   // Errors in the running test
  int n_err     = 0;
  int n_tests   = 0;
  int n_failed  = 0;

  assign err_total = n_err;

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset_cfg1";
      2:       return "enable_gating";
      3:       return "status_icr";
      4:       return "rxne_txis";
      5:       return "interrupt";
      6:       return "cr_hw_clear";
      default: return "unknown";
    endcase
  endfunction

  task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
    n_checks++;
    if (exp !== act) begin
      $display("** Error %s %s: expected %0h, actual %0h", test_name(test_id), what, exp, act);
      test_errs++;
      n_err++;
    end
  endtask

  // ----------------------------------------------------------
  // Mid-cycle sampling, inputs change on the rising edge
  // ----------------------------------------------------------
  always @(negedge pclk) begin
    if (chk_on) begin
      compare("txdr_we", 64'(exp_txdr_we), 64'(txdr_we));
      compare("rxdr_rd", 64'(exp_rxdr_rd), 64'(rxdr_rd));
      compare("control ports", 64'(exp_ctrl), 64'(act_ctrl));
      if (chk_rd) begin
        compare("iprdata", 64'(exp_rdata), 64'(iprdata));
      end
      if (chk_intr) begin
        compare("ucpd_intr", 64'(exp_intr), 64'(ucpd_intr));
      end
    end
    if (test_done) begin
      if (test_errs == 0) begin
        $display("test %0d %s: PASS", test_id, test_name(test_id));
      end else begin
        $display("test %0d %s: FAIL with %0d errors", test_id, test_name(test_id), test_errs);
        n_failed++;
      end
      n_tests++;
      test_errs = 0;
    end
    if (all_done) begin
      $display("%0d tests run, %0d passed, %0d failed, %0d checks, %0d errors",
               n_tests, n_tests - n_failed, n_failed, n_checks, n_err);
    end
  end

endmodule

// ==== test/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import ucpd_pkg::*; ();

  localparam int unsigned SYNC_STAGES = 2;
  localparam data_t       ICR_MASK    = 32'h0010_3e7e;   // SR bits 1-6, 9-13, 20
  localparam int          POLL_LIMIT  = 20;              // SR reads before giving up

  logic       pclk, presetn, wr_en, rd_en, frs_evt, txhrst_clr, txsend_clr;
  addr_t      reg_addr;
  data_t      ipwdata, iprdata;
  tx_status_t tx_status;
  rx_status_t rx_status;
  byte_t      rx_byte, ic_txdr;
  logic       ucpden, transmit_en, tx_hrst, phy_rx_en, txdr_we, rxdr_rd, ucpd_intr;
  logic [5:0] hbitclkdiv;
  logic [4:0] ifrgap, transwin;
  logic [2:0] psc_usbpdclk;
  logic [8:0] rx_ordset_en;
  logic [1:0] tx_mode;

  // To the checker
  int          test_id, err_total;
  logic        test_done, all_done, chk_on, chk_rd, chk_intr;
  logic        exp_intr, exp_txdr_we, exp_rxdr_rd;
  data_t       exp_rdata;
  logic [41:0] exp_ctrl, act_ctrl;

  // ----------------------------------------------------------
  // Reference model state
  // ----------------------------------------------------------
  data_t       m_cfg1, m_cr, m_imr, m_sr;
  byte_t       m_txdr, rx_val;
  logic [13:0] stat_vec;           // {frs, rx[5:0], tx[6:0]} levels
  logic        poll_mode;          // SR lags the model while polling
  int          cur_test;
  logic [31:0] seed = 32'd68894;

  tb_clk_gen #(.PERIOD(4.0)) clk_i (.clk(pclk));
  ucpd_regs_top #(.SYNC_STAGES(SYNC_STAGES)) dut_i (.*);
  tb_checker chk_i (.*);

  assign act_ctrl = {ucpden, hbitclkdiv, ifrgap, transwin, psc_usbpdclk, rx_ordset_en,
                     tx_mode, transmit_en, tx_hrst, phy_rx_en, ic_txdr};

  function automatic logic [31:0] next_rand();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  function automatic data_t model_read(input addr_t a);
    case (a)
      ADDR_CFG1: return m_cfg1;
      ADDR_CR:   return m_cr;
      ADDR_IMR:  return m_imr;
      ADDR_SR:   return m_sr;
      ADDR_TXDR: return {24'd0, m_txdr};
      ADDR_RXDR: return {24'd0, rx_val};
      default:   return '0;   // ICR and holes
    endcase
  endfunction

  function automatic logic [41:0] model_ctrl();
    return {m_cfg1[31], m_cfg1[5:0], m_cfg1[10:6], m_cfg1[15:11], m_cfg1[19:17],
            m_cfg1[28:20], m_cr[1:0], m_cr[2], m_cr[3], m_cr[5], m_txdr};
  endfunction

  // One bus cycle: drive on the edge, post expectations, then step the model
  task automatic access(input logic wr, input logic rd, input addr_t a, input data_t d,
                        input logic hclr, input logic sclr);
    logic en;
    @(posedge pclk);
    en = m_cfg1[31];
    wr_en <= wr;
    rd_en <= rd;
    reg_addr <= a;
    ipwdata <= d;
    txhrst_clr <= hclr;
    txsend_clr <= sclr;
    {frs_evt, rx_status, tx_status} <= stat_vec;
    rx_byte <= rx_val;
    {test_done, all_done, chk_on} <= 3'b001;
    test_id <= cur_test;
    chk_rd <= rd & ~poll_mode;
    chk_intr <= ~poll_mode;
    exp_rdata <= model_read(a);
    exp_intr <= |(m_imr & m_sr);      // Registered SR and IMR only
    exp_txdr_we <= wr & en & (a == ADDR_TXDR);
    exp_rxdr_rd <= rd & (a == ADDR_RXDR);
    exp_ctrl <= model_ctrl();
    if (wr && a == ADDR_CFG1) begin
      m_cfg1 = d[31] ? (m_cfg1 | 32'h8000_0000) : {1'b0, d[30:0]};
    end
    if (wr && en) begin
      case (a)
        ADDR_CR:   m_cr = d;
        ADDR_IMR:  m_imr = d;
        ADDR_ICR:  m_sr = m_sr & ~(d & ICR_MASK);
        ADDR_TXDR: begin
          m_txdr = d[7:0];
          m_sr[SR_TXIS_BIT] = 1'b0;
        end
        default: ;
      endcase
    end
    if (!(wr && en && a == ADDR_CR)) begin   // Software write beats hardware clears
      m_cr[3] = hclr ? 1'b0 : m_cr[3];
      m_cr[2] = sclr ? 1'b0 : m_cr[2];
    end
    if (rd && a == ADDR_RXDR) begin
      m_sr[SR_RXNE_BIT] = 1'b0;
    end
  endtask

  task automatic write_reg(input addr_t a, input data_t d);
    access(1'b1, 1'b0, a, d, 1'b0, 1'b0);
  endtask

  task automatic read_reg(input addr_t a);
    access(1'b0, 1'b1, a, '0, 1'b0, 1'b0);
  endtask

  task automatic idle_cycle();
    access(1'b0, 1'b0, '0, '0, 1'b0, 1'b0);
  endtask

  task automatic close_test();
    idle_cycle();
    test_done <= 1'b1;
  endtask

  // Raise one status input and poll SR until its bit shows up
  task automatic raise_status(input int idx);
    int n;
    int bitpos;
    bitpos = (idx < 7) ? idx : ((idx < 13) ? idx + 1 : 20);
    stat_vec[idx] = 1'b1;
    poll_mode = 1'b1;
    n = 0;
    do begin
      read_reg(ADDR_SR);
      @(negedge pclk);
      n++;
    end while (iprdata[bitpos] !== 1'b1 && n < POLL_LIMIT);
    if (iprdata[bitpos] !== 1'b1) begin
      $display("Timeout: SR bit %0d never set after status input %0d rose", bitpos, idx);
      $display("tests failed");
      $finish;
    end else begin
      m_sr[bitpos] = 1'b1;
      poll_mode = 1'b0;
      stat_vec[idx] = 1'b0;
      repeat (SYNC_STAGES + 2) idle_cycle();   // Let the low level settle
    end
  endtask

  initial begin
    data_t r;
    addr_t a;
    presetn = 1'b0;
    {wr_en, rd_en, frs_evt, txhrst_clr, txsend_clr} = '0;
    {reg_addr, ipwdata, tx_status, rx_status, rx_byte} = '0;
    {test_done, all_done, chk_on, chk_rd, chk_intr} = '0;
    {exp_intr, exp_txdr_we, exp_rxdr_rd, exp_rdata, exp_ctrl} = '0;
    {m_cfg1, m_cr, m_imr, m_sr, m_txdr, rx_val, stat_vec, poll_mode} = '0;
    test_id = 0;
    cur_test = 1;
    repeat (5) @(posedge pclk);
    presetn <= 1'b1;

    // ----------------------------------------------------------
    // Reset values and CFG1 enable protocol
    // ----------------------------------------------------------
    for (int i = 0; i < 16; i++) read_reg(addr_t'(i));
    for (int i = 0; i < 10; i++) begin
      write_reg(ADDR_CFG1, next_rand());
      read_reg(ADDR_CFG1);
    end
    close_test();

    cur_test = 2;   // Gated writes, random enable
    for (int i = 0; i < 16; i++) begin
      write_reg(ADDR_CFG1, next_rand());
      r = next_rand();
      a = (r[1:0] == 2'd0) ? ADDR_CR : ((r[1:0] == 2'd1) ? ADDR_IMR : ADDR_TXDR);
      write_reg(a, next_rand());
      read_reg(a);
    end
    close_test();

    cur_test = 3;
    write_reg(ADDR_CFG1, 32'h8000_0000);   // Enable, keep fields
    for (int i = 0; i < 10; i++) begin
      r = next_rand();
      raise_status(int'(r % 32'd14));
      read_reg(ADDR_SR);
      write_reg(ADDR_ICR, next_rand());
      read_reg(ADDR_SR);
    end
    close_test();

    cur_test = 4;   // RXNE from rx_status[0], TXIS from tx_status[0]
    for (int i = 0; i < 6; i++) begin
      raise_status(7);
      write_reg(ADDR_RXDR, next_rand());   // RXDR is read only and ignores writes
      r = next_rand();
      rx_val = r[7:0];
      read_reg(ADDR_RXDR);
      read_reg(ADDR_SR);
      raise_status(0);
      write_reg(ADDR_TXDR, next_rand());
      read_reg(ADDR_SR);
    end
    close_test();

    cur_test = 5;   // Interrupt checked every cycle
    for (int i = 0; i < 40; i++) begin
      r = next_rand();
      case (r[2:0])
        3'd0, 3'd1: write_reg(ADDR_IMR, next_rand());
        3'd2:       write_reg(ADDR_ICR, next_rand());
        3'd3:       raise_status(int'(r[15:8] % 8'd14));
        3'd4:       read_reg(ADDR_SR);
        3'd5:       read_reg(ADDR_RXDR);
        3'd6:       write_reg(ADDR_TXDR, next_rand());
        default:    write_reg(ADDR_CR, next_rand());
      endcase
    end
    close_test();

    cur_test = 6;   // Hardware clears against CR writes
    for (int i = 0; i < 16; i++) begin
      write_reg(ADDR_CR, next_rand() | 32'h0000_000c);
      r = next_rand();
      access(r[0], 1'b0, ADDR_CR, next_rand(), r[1], r[2]);
      read_reg(ADDR_CR);
    end
    close_test();

    idle_cycle();
    all_done <= 1'b1;
    idle_cycle();
    @(posedge pclk);
    if (err_total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
rtl/ucpd_pkg.sv
rtl/ucpd_status_if.sv
rtl/ucpd_reg_bank.sv
rtl/ucpd_event_capture.sv
rtl/ucpd_status_reg.sv
rtl/ucpd_regs_top.sv
test/tb_clk_gen.sv
test/tb_checker.sv
test/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the UCPD register block testbench with Verilator
verilator --binary --timing -f list.f --top-module tb_top -Mdir obj_dir -o tb_sim \
  > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat build.log; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
